/* source/exu_pkg.sv */
//==========================================================================
// Widths, vector types and opcodes shared by the execute stage.
// PCs are halfword addresses and bit 0 is always zero.
//==========================================================================
package exu_pkg;

   typedef logic [31:0] data_t;    // Operand or result word
   typedef logic [31:1] pc_t;      // Halfword-aligned PC
   typedef logic [12:1] brimm_t;   // Branch or JAL offset in halfwords
   typedef logic [3:0]  byp_t;     // One-hot {nb load, X, M load, R}

   typedef enum logic [3:0] {
      ADD    = 4'd0,
      SUB    = 4'd1,
      AND    = 4'd2,
      OR     = 4'd3,
      XOR    = 4'd4,
      SLL    = 4'd5,
      SRL    = 4'd6,
      SRA    = 4'd7,
      SLT    = 4'd8,
      SLTU   = 4'd9,
      PASS_B = 4'd10               // Immediate or rs2 straight through
   } alu_op_t;

   typedef enum logic [2:0] {
      NONE = 3'd0,                 // Not a control transfer
      BEQ  = 3'd1,
      BNE  = 3'd2,
      BLT  = 3'd3,
      BGE  = 3'd4,
      BLTU = 3'd5,
      BGEU = 3'd6,
      JAL  = 3'd7                  // Always actually taken
   } br_op_t;

   typedef enum logic [1:0] {
      MUL    = 2'd0,               // Low word
      MULH   = 2'd1,               // High word, signed x signed
      MULHU  = 2'd2,               // High word, unsigned x unsigned
      MULHSU = 2'd3                // High word, signed x unsigned
   } mul_op_t;

   // Next sequential PC, 4 bytes expressed in halfwords
   localparam pc_t PC4_INC = 31'd2;

endpackage

/* source/exu_operand_sel.sv */
//==========================================================================
// D-stage operand selection. Bypass selects must be one-hot or zero;
// several set bits OR their sources together.
//==========================================================================
`timescale 1ns/1ps

module exu_operand_sel
   import exu_pkg::*;
(
   input  byp_t  i_rs1_byp_d,      // rs1 bypass select
   input  byp_t  i_rs2_byp_d,      // rs2 bypass select
   input  logic  i_rs1_en_d,       // Qualify GPR rs1
   input  logic  i_rs2_en_d,       // Qualify GPR rs2
   input  logic  i_select_pc_d,    // PC as rs1
   input  pc_t   i_pc_d,
   input  data_t i_gpr_rs1_d,
   input  data_t i_gpr_rs2_d,
   input  data_t i_immed_d,
   input  data_t i_result_r,       // R-stage result
   input  data_t i_lsu_result_m,   // M-stage load result
   input  data_t i_result_x,       // X-stage result loop
   input  data_t i_lsu_nb_data,    // Non-blocking load data
   output data_t o_rs1_d,
   output data_t o_rs2_d
);

   logic  rs1_byp_en;
   logic  rs2_byp_en;
   data_t rs1_byp_data;
   data_t rs2_byp_data;

   assign rs1_byp_en = |i_rs1_byp_d;
   assign rs2_byp_en = |i_rs2_byp_d;

   // AND-OR select, no priority between sources
   assign rs1_byp_data = ({32{i_rs1_byp_d[0]}} & i_result_r)     |
                         ({32{i_rs1_byp_d[1]}} & i_lsu_result_m) |
                         ({32{i_rs1_byp_d[2]}} & i_result_x)     |
                         ({32{i_rs1_byp_d[3]}} & i_lsu_nb_data);

   assign rs2_byp_data = ({32{i_rs2_byp_d[0]}} & i_result_r)     |
                         ({32{i_rs2_byp_d[1]}} & i_lsu_result_m) |
                         ({32{i_rs2_byp_d[2]}} & i_result_x)     |
                         ({32{i_rs2_byp_d[3]}} & i_lsu_nb_data);

   always_comb begin
      if (rs1_byp_en) begin
         o_rs1_d = rs1_byp_data;
      end else if (i_select_pc_d) begin
         o_rs1_d = {i_pc_d, 1'b0};  // For JAL and AUIPC-style ops
      end else if (i_rs1_en_d) begin
         o_rs1_d = i_gpr_rs1_d;
      end else begin
         o_rs1_d = '0;
      end
   end

   always_comb begin
      if (rs2_byp_en) begin
         o_rs2_d = rs2_byp_data;
      end else if (i_rs2_en_d) begin
         o_rs2_d = i_gpr_rs2_d;
      end else begin
         o_rs2_d = i_immed_d;
      end
   end

   // Decode must never point one operand at two producers
   a_rs1_byp_onehot: assert final ($isunknown(i_rs1_byp_d) || $onehot0(i_rs1_byp_d));
   a_rs2_byp_onehot: assert final ($isunknown(i_rs2_byp_d) || $onehot0(i_rs2_byp_d));

endmodule

/* source/exu_alu.sv */
//==========================================================================
// X-stage ALU with branch resolution. D inputs load on i_x_en only.
// Result and upper flush are combinational from the X registers.
// JAL writes the byte address of the next sequential instruction.
//==========================================================================
`timescale 1ns/1ps

module exu_alu
   import exu_pkg::*;
(
   input  logic    clk,
   input  logic    i_rst,
   input  logic    i_x_en,            // X-stage load strobe
   input  logic    i_valid_d,
   input  logic    i_flush_lower_r,   // Kills the instruction entering X
   input  logic    i_pred_taken_d,
   input  alu_op_t i_op_d,
   input  br_op_t  i_br_op_d,
   input  data_t   i_a_d,
   input  data_t   i_b_d,
   input  pc_t     i_pc_d,
   input  brimm_t  i_brimm_d,
   output data_t   o_result_x,
   output pc_t     o_pc_x,
   output logic    o_br_valid_x,
   output logic    o_actual_taken_x,
   output logic    o_flush_upper_x,   // Direction mispredict
   output pc_t     o_flush_path_x
);

   logic    valid_x;
   alu_op_t op_x;
   br_op_t  br_op_x;
   logic    pred_taken_x;
   data_t   a_x;
   data_t   b_x;
   pc_t     pc_x;
   brimm_t  brimm_x;
   data_t   alu_out;
   logic    eq;
   logic    lt;
   logic    ltu;
   pc_t     offset_x;

   always_ff @(posedge clk) begin
      if (i_rst) begin
         valid_x      <= 1'b0;
         op_x         <= ADD;
         br_op_x      <= NONE;
         pred_taken_x <= 1'b0;
      end else if (i_x_en) begin
         valid_x      <= i_valid_d & ~i_flush_lower_r;
         op_x         <= i_op_d;
         br_op_x      <= i_br_op_d;
         pred_taken_x <= i_pred_taken_d;
      end
   end

   always_ff @(posedge clk) begin
      if (i_x_en) begin
         a_x     <= i_a_d;
         b_x     <= i_b_d;
         pc_x    <= i_pc_d;
         brimm_x <= i_brimm_d;
      end
   end

   assign eq  = (a_x == b_x);
   assign lt  = ($signed(a_x) < $signed(b_x));
   assign ltu = (a_x < b_x);

   always_comb begin
      case (op_x)
         ADD:     alu_out = a_x + b_x;
         SUB:     alu_out = a_x - b_x;
         AND:     alu_out = a_x & b_x;
         OR:      alu_out = a_x | b_x;
         XOR:     alu_out = a_x ^ b_x;
         SLL:     alu_out = a_x << b_x[4:0];
         SRL:     alu_out = a_x >> b_x[4:0];
         SRA:     alu_out = data_t'($signed(a_x) >>> b_x[4:0]);
         SLT:     alu_out = {31'd0, lt};
         SLTU:    alu_out = {31'd0, ltu};
         default: alu_out = b_x;  // PASS_B
      endcase
   end

   // Link address for JAL
   assign o_result_x = (br_op_x == JAL) ? {pc_x + PC4_INC, 1'b0} : alu_out;
   assign o_pc_x     = pc_x;

   always_comb begin
      case (br_op_x)
         BEQ:     o_actual_taken_x = eq;
         BNE:     o_actual_taken_x = ~eq;
         BLT:     o_actual_taken_x = lt;
         BGE:     o_actual_taken_x = ~lt;
         BLTU:    o_actual_taken_x = ltu;
         BGEU:    o_actual_taken_x = ~ltu;
         JAL:     o_actual_taken_x = 1'b1;
         default: o_actual_taken_x = 1'b0;
      endcase
   end

   assign o_br_valid_x    = valid_x & (br_op_x != NONE);
   assign o_flush_upper_x = o_br_valid_x & (o_actual_taken_x ^ pred_taken_x);

   assign offset_x       = {{19{brimm_x[12]}}, brimm_x};  // Sign extend
   assign o_flush_path_x = o_actual_taken_x ? (pc_x + offset_x) : (pc_x + PC4_INC);

   // A new mispredict needs a valid branch loaded by the previous edge
   a_flush_from_branch: assert property (@(posedge clk) disable iff (i_rst)
      $rose(o_flush_upper_x) |->
         $past(i_x_en && i_valid_d && !i_flush_lower_r && (i_br_op_d != NONE)));

   // A non-branch entering X never looks like a branch
   a_no_branch_none: assert property (@(posedge clk) disable iff (i_rst)
      $past(i_x_en) && $past(i_br_op_d == NONE) |-> !o_br_valid_x);

endmodule

/* source/exu_mul.sv */
//==========================================================================
// 32x32 multiplier, product formed at D and one word registered at X.
// Operands read as zero when the unit is not selected.
//==========================================================================
`timescale 1ns/1ps

module exu_mul
   import exu_pkg::*;
(
   input  logic    clk,
   input  logic    i_rst,
   input  logic    i_x_en,       // X-stage load strobe
   input  logic    i_valid_d,
   input  mul_op_t i_op_d,
   input  data_t   i_a_d,
   input  data_t   i_b_d,
   output logic    o_valid_x,
   output data_t   o_result_x
);

   data_t              a_g;
   data_t              b_g;
   logic               a_sign;
   logic               b_sign;
   logic signed [32:0] a_ext;
   logic signed [32:0] b_ext;
   logic signed [63:0] prod;

   // Quiet the array when no multiply is issued
   assign a_g = i_a_d & {32{i_valid_d}};
   assign b_g = i_b_d & {32{i_valid_d}};

   assign a_sign = (i_op_d == MULH) | (i_op_d == MULHSU);
   assign b_sign = (i_op_d == MULH);

   assign a_ext = {a_sign & a_g[31], a_g};
   assign b_ext = {b_sign & b_g[31], b_g};
   assign prod  = a_ext * b_ext;  // Low 64 bits are exact for all sign mixes

   always_ff @(posedge clk) begin
      if (i_rst) begin
         o_valid_x <= 1'b0;
      end else if (i_x_en) begin
         o_valid_x <= i_valid_d;
      end
   end

   always_ff @(posedge clk) begin
      if (i_x_en) begin
         o_result_x <= (i_op_d == MUL) ? prod[31:0] : prod[63:32];
      end
   end

endmodule

/* source/exu_ghr.sv */
//==========================================================================
// Global branch history, speculative at D and committed at X.
// Restore priority at D is lower flush, then upper flush, then shift.
// GHR_SIZE is legal from 2 to 16.
//==========================================================================
`timescale 1ns/1ps

module exu_ghr
   import exu_pkg::*;
#(
   parameter int GHR_SIZE = 8
) (
   input  logic                clk,
   input  logic                i_rst,
   input  logic                i_x_en,
   input  logic                i_br_valid_d,
   input  logic                i_pred_taken_d,
   input  logic                i_br_valid_x,
   input  logic                i_actual_taken_x,
   input  logic                i_flush_upper_x,
   input  logic                i_flush_lower_r,
   output logic [GHR_SIZE-1:0] o_ghr_d,
   output logic [GHR_SIZE-1:0] o_ghr_x
);

   logic [GHR_SIZE-1:0] ghr_x_ns;
   logic [GHR_SIZE-1:0] ghr_d_ns;

   // Committed history takes the resolved direction
   assign ghr_x_ns = (i_br_valid_x & i_x_en) ? {o_ghr_x[GHR_SIZE-2:0], i_actual_taken_x}
                                              : o_ghr_x;

   always_comb begin
      if (i_flush_lower_r) begin
         ghr_d_ns = o_ghr_x;        // Trap drops everything past X
      end else if (i_flush_upper_x) begin
         ghr_d_ns = ghr_x_ns;       // Keeps the resolved branch
      end else if (i_br_valid_d & i_x_en) begin
         ghr_d_ns = {o_ghr_d[GHR_SIZE-2:0], i_pred_taken_d};
      end else begin
         ghr_d_ns = o_ghr_d;
      end
   end

   always_ff @(posedge clk) begin
      if (i_rst) begin
         o_ghr_x <= '0;
         o_ghr_d <= '0;
      end else begin
         o_ghr_x <= ghr_x_ns;
         o_ghr_d <= ghr_d_ns;
      end
   end

   // After a mispredict alone both copies agree, so no D shift slipped in
   a_upper_restore: assert property (@(posedge clk) disable iff (i_rst)
      i_flush_upper_x && !i_flush_lower_r |=> (o_ghr_d == o_ghr_x));

endmodule

/* source/exu_top.sv */
//==========================================================================
// Single-issue integer execute stage. All X state loads on i_x_en.
// Final flush is combinational; the lower (trap) flush wins over the
// upper (mispredict) flush. ALU and multiplier never issue together.
//==========================================================================
`timescale 1ns/1ps

module exu_top
   import exu_pkg::*;
#(
   parameter int GHR_SIZE = 8
) (
   input  logic                clk,
   input  logic                i_rst,
   input  logic                i_x_en,             // X-stage enable strobe
   input  logic                i_alu_valid_d,
   input  alu_op_t             i_alu_op_d,
   input  br_op_t              i_br_op_d,
   input  logic                i_pred_taken_d,
   input  pc_t                 i_pc_d,
   input  brimm_t              i_brimm_d,
   input  logic                i_mul_valid_d,
   input  mul_op_t             i_mul_op_d,
   input  byp_t                i_rs1_byp_d,
   input  byp_t                i_rs2_byp_d,
   input  logic                i_rs1_en_d,
   input  logic                i_rs2_en_d,
   input  logic                i_select_pc_d,
   input  data_t               i_gpr_rs1_d,
   input  data_t               i_gpr_rs2_d,
   input  data_t               i_immed_d,
   input  data_t               i_result_r,
   input  data_t               i_lsu_result_m,
   input  data_t               i_lsu_nb_data,
   input  logic                i_flush_lower_r,    // Trap flush from R
   input  pc_t                 i_flush_path_r,
   output data_t               o_result_x,
   output pc_t                 o_pc_x,
   output logic                o_mul_valid_x,
   output logic                o_flush_final,
   output pc_t                 o_flush_path_final,
   output logic [GHR_SIZE-1:0] o_ghr_d,
   output logic [GHR_SIZE-1:0] o_ghr_x
);

   data_t rs1_d;
   data_t rs2_d;
   data_t alu_result_x;
   data_t mul_result_x;
   logic  br_valid_d;
   logic  br_valid_x;
   logic  actual_taken_x;
   logic  flush_upper_x;
   pc_t   flush_path_x;

   assign br_valid_d = i_alu_valid_d & (i_br_op_d != NONE);

   exu_operand_sel u_operand_sel (
      .i_rs1_byp_d   (i_rs1_byp_d),
      .i_rs2_byp_d   (i_rs2_byp_d),
      .i_rs1_en_d    (i_rs1_en_d),
      .i_rs2_en_d    (i_rs2_en_d),
      .i_select_pc_d (i_select_pc_d),
      .i_pc_d        (i_pc_d),
      .i_gpr_rs1_d   (i_gpr_rs1_d),
      .i_gpr_rs2_d   (i_gpr_rs2_d),
      .i_immed_d     (i_immed_d),
      .i_result_r    (i_result_r),
      .i_lsu_result_m(i_lsu_result_m),
      .i_result_x    (o_result_x),      // X result loops back
      .i_lsu_nb_data (i_lsu_nb_data),
      .o_rs1_d       (rs1_d),
      .o_rs2_d       (rs2_d)
   );

   exu_alu u_alu (
      .clk             (clk),
      .i_rst           (i_rst),
      .i_x_en          (i_x_en),
      .i_valid_d       (i_alu_valid_d),
      .i_flush_lower_r (i_flush_lower_r),
      .i_pred_taken_d  (i_pred_taken_d),
      .i_op_d          (i_alu_op_d),
      .i_br_op_d       (i_br_op_d),
      .i_a_d           (rs1_d),
      .i_b_d           (rs2_d),
      .i_pc_d          (i_pc_d),
      .i_brimm_d       (i_brimm_d),
      .o_result_x      (alu_result_x),
      .o_pc_x          (o_pc_x),
      .o_br_valid_x    (br_valid_x),
      .o_actual_taken_x(actual_taken_x),
      .o_flush_upper_x (flush_upper_x),
      .o_flush_path_x  (flush_path_x)
   );

   exu_mul u_mul (
      .clk       (clk),
      .i_rst     (i_rst),
      .i_x_en    (i_x_en),
      .i_valid_d (i_mul_valid_d),
      .i_op_d    (i_mul_op_d),
      .i_a_d     (rs1_d),
      .i_b_d     (rs2_d),
      .o_valid_x (o_mul_valid_x),
      .o_result_x(mul_result_x)
   );

   exu_ghr #(
      .GHR_SIZE(GHR_SIZE)
   ) u_ghr (
      .clk             (clk),
      .i_rst           (i_rst),
      .i_x_en          (i_x_en),
      .i_br_valid_d    (br_valid_d),
      .i_pred_taken_d  (i_pred_taken_d),
      .i_br_valid_x    (br_valid_x),
      .i_actual_taken_x(actual_taken_x),
      .i_flush_upper_x (flush_upper_x),
      .i_flush_lower_r (i_flush_lower_r),
      .o_ghr_d         (o_ghr_d),
      .o_ghr_x         (o_ghr_x)
   );

   assign o_result_x = o_mul_valid_x ? mul_result_x : alu_result_x;

   // Oldest flush source picks the redirect
   assign o_flush_final      = i_flush_lower_r | flush_upper_x;
   assign o_flush_path_final = i_flush_lower_r ? i_flush_path_r : flush_path_x;

   // Shared result port relies on exclusive issue
   a_alu_mul_excl: assert property (@(posedge clk) disable iff (i_rst)
      i_x_en |-> !(i_alu_valid_d && i_mul_valid_d));

endmodule

/* verif/exu_tb.sv */
//==========================================================================
// Directed testbench for exu_top with an ISA-level reference model.
// GHR_SIZE here is passed to the DUT and sizes the history checks.
// Inputs change on rising edges and outputs are sampled on falling edges.
//==========================================================================
`timescale 1ns/1ps

module exu_tb;
   import exu_pkg::*;

   localparam int GHR_SIZE  = 8;
   localparam int GHR_STEPS = 200;
   // Reset, alu, operands, mul, branch, lower flush, history
   localparam int TEST_CYCLES = 5 + 95 + 30 + 48 + 64 + 8 + (GHR_STEPS + 10);

   logic                clk = 1'b0;
   logic                i_rst = 1'b1;
   logic                i_x_en = 1'b0;
   logic                i_alu_valid_d = 1'b0;
   alu_op_t             i_alu_op_d = ADD;
   br_op_t              i_br_op_d = NONE;
   logic                i_pred_taken_d = 1'b0;
   pc_t                 i_pc_d = '0;
   brimm_t              i_brimm_d = '0;
   logic                i_mul_valid_d = 1'b0;
   mul_op_t             i_mul_op_d = MUL;
   byp_t                i_rs1_byp_d = '0;
   byp_t                i_rs2_byp_d = '0;
   logic                i_rs1_en_d = 1'b0;
   logic                i_rs2_en_d = 1'b0;
   logic                i_select_pc_d = 1'b0;
   data_t               i_gpr_rs1_d = '0;
   data_t               i_gpr_rs2_d = '0;
   data_t               i_immed_d = '0;
   data_t               i_result_r = '0;
   data_t               i_lsu_result_m = '0;
   data_t               i_lsu_nb_data = '0;
   logic                i_flush_lower_r = 1'b0;
   pc_t                 i_flush_path_r = '0;
   data_t               o_result_x;
   pc_t                 o_pc_x;
   logic                o_mul_valid_x;
   logic                o_flush_final;
   pc_t                 o_flush_path_final;
   logic [GHR_SIZE-1:0] o_ghr_d;
   logic [GHR_SIZE-1:0] o_ghr_x;

   integer seed;
   int     errors = 0;

   exu_top #(.GHR_SIZE(GHR_SIZE)) dut (.*);

   always #10 clk = ~clk;

   task automatic check_data(input string name, input data_t exp, input data_t act);
      if (act !== exp) begin
         errors++;
         $display("** Error %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_pc(input string name, input pc_t exp, input pc_t act);
      if (act !== exp) begin
         errors++;
         $display("** Error %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         errors++;
         $display("** Error %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   task automatic check_ghr(input string name, input logic [GHR_SIZE-1:0] exp,
                            input logic [GHR_SIZE-1:0] act);
      if (act !== exp) begin
         errors++;
         $display("** Error %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   function automatic data_t alu_model(input alu_op_t op, input data_t a, input data_t b);
      logic [63:0] ext;
      ext = {{32{a[31]}}, a};          // Sign fill for arithmetic shift
      case (op)
         ADD:     return a + b;
         SUB:     return a + ~b + 32'd1;
         AND:     return a & b;
         OR:      return a | b;
         XOR:     return a ^ b;
         SLL:     return a << b[4:0];
         SRL:     return a >> b[4:0];
         SRA:     return data_t'(ext >> b[4:0]);
         SLT:     return data_t'((a[31] != b[31]) ? a[31] : (a < b));
         SLTU:    return data_t'(a < b);
         default: return b;
      endcase
   endfunction

   function automatic logic taken_model(input br_op_t br, input data_t a, input data_t b);
      logic slt;
      slt = (a[31] != b[31]) ? a[31] : (a < b);
      case (br)
         BEQ:     return a == b;
         BNE:     return a != b;
         BLT:     return slt;
         BGE:     return !slt;
         BLTU:    return a < b;
         BGEU:    return a >= b;
         JAL:     return 1'b1;
         default: return 1'b0;
      endcase
   endfunction

   function automatic data_t mul_model(input mul_op_t op, input data_t a, input data_t b);
      logic [63:0] ae;
      logic [63:0] be;
      logic [63:0] p;
      ae = (op == MULH || op == MULHSU) ? {{32{a[31]}}, a} : {32'd0, a};
      be = (op == MULH) ? {{32{b[31]}}, b} : {32'd0, b};
      p  = ae * be;                    // Exact modulo 2^64
      return (op == MUL) ? p[31:0] : p[63:32];
   endfunction

   function automatic data_t byp_model(input byp_t byp, input data_t x);
      data_t v;
      v = '0;
      if (byp[0]) v |= i_result_r;
      if (byp[1]) v |= i_lsu_result_m;
      if (byp[2]) v |= x;
      if (byp[3]) v |= i_lsu_nb_data;
      return v;
   endfunction

   task automatic apply_reset;
      @(posedge clk);
      i_rst           <= 1'b1;
      i_x_en          <= 1'b0;
      i_alu_valid_d   <= 1'b0;
      i_mul_valid_d   <= 1'b0;
      i_flush_lower_r <= 1'b0;
      repeat (4) @(posedge clk);
      i_rst <= 1'b0;
   endtask

   // ALU or branch op with plain GPR operands and X enabled at the next edge
   task automatic drive_alu(input alu_op_t op, input br_op_t br, input logic pred,
                            input data_t a, input data_t b);
      @(posedge clk);
      i_x_en         <= 1'b1;
      i_alu_valid_d  <= 1'b1;
      i_mul_valid_d  <= 1'b0;
      i_alu_op_d     <= op;
      i_br_op_d      <= br;
      i_pred_taken_d <= pred;
      i_rs1_byp_d    <= '0;
      i_rs2_byp_d    <= '0;
      i_rs1_en_d     <= 1'b1;
      i_rs2_en_d     <= 1'b1;
      i_select_pc_d  <= 1'b0;
      i_gpr_rs1_d    <= a;
      i_gpr_rs2_d    <= b;
   endtask

   task automatic load_x;
      @(posedge clk);
      i_x_en <= 1'b0;                  // X holds after this edge
      @(negedge clk);
   endtask

   task automatic test_alu;
      alu_op_t op;
      data_t   a;
      data_t   b;
      data_t   exp;
      for (int r = 0; r < 4; r++) begin
         for (int k = 0; k <= 10; k++) begin
            op = alu_op_t'(k);
            a  = data_t'($random(seed));
            b  = data_t'($random(seed));
            drive_alu(op, NONE, 1'b0, a, b);
            load_x;
            exp = alu_model(op, a, b);
            check_data($sformatf("alu %s", op.name()), exp, o_result_x);
         end
      end
      drive_alu(ADD, NONE, 1'b0, ~a, ~b);
      i_x_en <= 1'b0;                  // New D inputs under a stall
      repeat (3) @(posedge clk);
      @(negedge clk);
      check_data("alu stall hold", exp, o_result_x);
   endtask

   task automatic test_operands;
      data_t a;
      data_t b;
      data_t exp;
      @(posedge clk);
      i_result_r     <= data_t'($random(seed));
      i_lsu_result_m <= data_t'($random(seed));
      i_lsu_nb_data  <= data_t'($random(seed));
      i_immed_d      <= data_t'($random(seed));
      i_pc_d         <= pc_t'($random(seed));
      for (int k = 0; k < 4; k++) begin
         if (k == 2) continue;         // X source runs back to back below
         a = data_t'($random(seed));
         b = data_t'($random(seed));
         drive_alu(ADD, NONE, 1'b0, a, b);
         i_rs1_byp_d <= byp_t'(1 << k);
         load_x;
         exp = byp_model(byp_t'(1 << k), '0) + b;
         check_data($sformatf("rs1 bypass %0d", k), exp, o_result_x);
         drive_alu(PASS_B, NONE, 1'b0, a, b);
         i_rs2_byp_d <= byp_t'(1 << k);
         load_x;
         check_data($sformatf("rs2 bypass %0d", k), byp_model(byp_t'(1 << k), '0), o_result_x);
      end
      for (int k = 0; k < 4; k++) begin
         a = data_t'($random(seed));
         b = data_t'($random(seed));
         drive_alu(ADD, NONE, 1'b0, a, b);
         i_rs1_en_d <= k[0];
         i_rs2_en_d <= k[1];
         load_x;
         exp = (k[0] ? a : 32'd0) + (k[1] ? b : i_immed_d);
         check_data($sformatf("operand enables %0d", k), exp, o_result_x);
      end
      drive_alu(ADD, NONE, 1'b0, a, b);
      i_select_pc_d <= 1'b1;
      i_rs2_en_d    <= 1'b0;
      load_x;
      check_data("pc select", data_t'({i_pc_d, 1'b0}) + i_immed_d, o_result_x);
      drive_alu(ADD, NONE, 1'b0, a, b);
      drive_alu(ADD, NONE, 1'b0, a, b);   // Uses the first op's X result
      i_rs1_byp_d <= 4'b0100;
      i_rs2_byp_d <= 4'b0100;
      @(negedge clk);
      check_data("x result", a + b, o_result_x);
      load_x;
      exp = byp_model(4'b0100, a + b) + byp_model(4'b0100, a + b);
      check_data("x bypass", exp, o_result_x);
   endtask

   task automatic test_mul;
      data_t   ca [4] = '{32'h8000_0000, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
      data_t   cb [4] = '{32'hffff_ffff, 32'hffff_ffff, 32'h8000_0000, 32'h8000_0000};
      mul_op_t op;
      data_t   a;
      data_t   b;
      for (int j = 0; j < 6; j++) begin
         a = (j < 4) ? ca[j] : data_t'($random(seed));
         b = (j < 4) ? cb[j] : data_t'($random(seed));
         for (int k = 0; k < 4; k++) begin
            op = mul_op_t'(k);
            drive_alu(XOR, NONE, 1'b0, a, b);   // ALU loads too but loses the mux
            i_alu_valid_d <= 1'b0;
            i_mul_valid_d <= 1'b1;
            i_mul_op_d    <= op;
            load_x;
            check_bit("mul valid", 1'b1, o_mul_valid_x);
            check_data($sformatf("mul %s", op.name()), mul_model(op, a, b), o_result_x);
         end
      end
   endtask

   task automatic test_branch;
      br_op_t br;
      data_t  a;
      data_t  b;
      pc_t    pc;
      brimm_t imm;
      logic   taken;
      logic   flush;
      for (int k = 0; k < 8; k++) begin
         for (int m = 0; m < 4; m++) begin
            br  = br_op_t'(k);
            a   = data_t'($random(seed));
            b   = m[1] ? a : data_t'($random(seed));
            pc  = pc_t'($random(seed));
            imm = brimm_t'($random(seed));
            drive_alu(ADD, br, m[0], a, b);
            i_pc_d    <= pc;
            i_brimm_d <= imm;
            load_x;
            taken = taken_model(br, a, b);
            flush = (br != NONE) && (taken != m[0]);
            check_bit($sformatf("flush %s", br.name()), flush, o_flush_final);
            check_bit("mul valid low", 1'b0, o_mul_valid_x);
            check_pc("pc x", pc, o_pc_x);
            if (flush) begin
               check_pc($sformatf("path %s", br.name()),
                        taken ? pc + pc_t'($signed(imm)) : pc + 31'd2, o_flush_path_final);
            end
            if (br == JAL) begin
               check_data("jal link", data_t'({pc, 1'b0}) + 32'd4, o_result_x);
            end
         end
      end
   endtask

   task automatic test_lower_flush;
      data_t a;
      pc_t   path;
      a    = data_t'($random(seed));
      path = pc_t'($random(seed));
      drive_alu(ADD, BEQ, 1'b0, a, a);  // Taken but predicted not taken
      load_x;
      check_bit("upper flush", 1'b1, o_flush_final);
      drive_alu(ADD, BEQ, 1'b0, a, a);
      i_flush_lower_r <= 1'b1;
      i_flush_path_r  <= path;
      @(negedge clk);
      check_bit("lower flush", 1'b1, o_flush_final);
      check_pc("lower flush path", path, o_flush_path_final);
      @(posedge clk);
      i_flush_lower_r <= 1'b0;
      i_x_en          <= 1'b0;
      @(negedge clk);
      check_bit("killed branch", 1'b0, o_flush_final);
   endtask

   task automatic test_ghr;
      logic [GHR_SIZE-1:0] gd;
      logic [GHR_SIZE-1:0] gx;
      logic [GHR_SIZE-1:0] nx;
      logic                xv;
      br_op_t              xbr;
      logic                xpred;
      data_t               xa;
      data_t               xb;
      logic                tx;
      logic                fu;
      data_t               a;
      data_t               r;
      apply_reset;
      gd    = '0;
      gx    = '0;
      xv    = 1'b0;
      xbr   = NONE;
      xpred = 1'b0;
      xa    = '0;
      xb    = '0;
      repeat (GHR_STEPS) begin
         @(negedge clk);
         check_ghr("ghr d", gd, o_ghr_d);
         check_ghr("ghr x", gx, o_ghr_x);
         // Next edge from the X model and the inputs now at D
         tx = taken_model(xbr, xa, xb);
         fu = xv && (xbr != NONE) && (tx != xpred);
         nx = (xv && (xbr != NONE) && i_x_en) ? {gx[GHR_SIZE-2:0], tx} : gx;
         if (i_flush_lower_r) begin
            gd = gx;
         end else if (fu) begin
            gd = nx;
         end else if (i_alu_valid_d && (i_br_op_d != NONE) && i_x_en) begin
            gd = {gd[GHR_SIZE-2:0], i_pred_taken_d};
         end
         gx = nx;
         if (i_x_en) begin
            xv    = i_alu_valid_d && !i_flush_lower_r;
            xbr   = i_br_op_d;
            xpred = i_pred_taken_d;
            xa    = i_gpr_rs1_d;
            xb    = i_gpr_rs2_d;
         end
         a = data_t'($random(seed));
         r = data_t'($random(seed));
         drive_alu(ADD, br_op_t'(r[9:7]), r[10], a, r[11] ? a : data_t'($random(seed)));
         i_x_en          <= (r[1:0] != 2'd0);
         i_flush_lower_r <= (r[4:2] == 3'd0);
         i_alu_valid_d   <= r[5] | r[6];
         i_flush_path_r  <= pc_t'(r);
      end
      @(negedge clk);
      check_ghr("ghr d", gd, o_ghr_d);
      check_ghr("ghr x", gx, o_ghr_x);
   endtask

   initial begin
      #(TEST_CYCLES * 2 * 20);
      $display("Watchdog expired, the tests did not finish in time");
      $display("Checks failed");
      $finish;
   end

   initial begin
      seed = 32'hda29;
      apply_reset;
      test_alu;
      test_operands;
      test_mul;
      test_branch;
      test_lower_flush;
      test_ghr;
      $display("Error count: %0d", errors);
      if (errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

/* files.f */
source/exu_pkg.sv
source/exu_operand_sel.sv
source/exu_alu.sv
source/exu_mul.sv
source/exu_ghr.sv
source/exu_top.sv
verif/exu_tb.sv

/* Bender.yml */
package:
  name: exu_stage

sources:
  - files:
      - source/exu_pkg.sv
      - source/exu_operand_sel.sv
      - source/exu_alu.sv
      - source/exu_mul.sv
      - source/exu_ghr.sv
      - source/exu_top.sv
  - target: test
    files:
      - verif/exu_tb.sv
